// File: common/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc and memory address width
`define FETCH_ADDR_W 32

// direct-mapped cache, 16 sets
`define LG_L1I_SETS 4

// 16-byte lines, four words each
`define LG_CL_BYTES 4

// bimodal table entries
`define LG_PHT_SZ 6

// fetch queue depth
`define LG_FQ_ENTRIES 3

`endif

// File: common/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

   // branch class of one cached word, computed at refill
   typedef enum logic [1:0]
   {
      PD_NONE,
      PD_COND,
      PD_ALWAYS,
      PD_JUMP
   } pd_class_t;

   typedef enum logic [2:0]
   {
      INIT_PHT,
      FLUSH_CACHE,
      IDLE,
      ACTIVE,
      INJECT_RELOAD,
      RELOAD_TURNAROUND,
      WAIT_FOR_NOT_FULL
   } fetch_state_t;

   // one queue entry handed to the core
   typedef struct packed
   {
      logic [31:0] data;
      logic [`FETCH_ADDR_W-1:0] pc;
      logic pred;
      // prediction came from the pht counter
      logic pred_cond;
   } fetch_insn_t;

   typedef struct packed
   {
      logic [`FETCH_ADDR_W-1:0] pc;
      logic taken;
   } retire_br_t;

endpackage

// File: common/mem_pkg.sv
`include "fetch_defs.svh"

package mem_pkg;

   typedef enum logic [3:0]
   {
      MEM_LW,
      MEM_SW
   } mem_op_t;

   // line-aligned refill request
   typedef struct packed
   {
      logic [`FETCH_ADDR_W-1:0] addr;
      mem_op_t opcode;
   } mem_req_t;

   // whole line, word 0 in the low bits
   typedef struct packed
   {
      logic [(8 << `LG_CL_BYTES)-1:0] line;
   } mem_rsp_t;

endpackage

// File: l1i/predecode.sv
`timescale 1ns/1ps

module predecode
(
   input logic [31:0] word,
   output fetch_pkg::pd_class_t pd
);
   import fetch_pkg::*;

   logic [5:0] opcode;
   logic [4:0] rs;
   logic [4:0] rt;

   assign opcode = word[31:26];
   assign rs = word[25:21];
   assign rt = word[20:16];

   always_comb
   begin
      case (opcode)
         // regimm, rt picks plain or likely
         6'd1:
         begin
            casez (rt)
               5'b?000?: pd = PD_COND;
               5'b?001?: pd = PD_ALWAYS;
               default: pd = PD_NONE;
            endcase
         end
         // j and jal
         6'd2, 6'd3:
            pd = PD_JUMP;
         // beq r0, r0 is the assembler's unconditional b
         6'd4:
         begin
            if (rs == 5'd0 && rt == 5'd0)
               pd = PD_ALWAYS;
            else
               pd = PD_COND;
         end
         6'd5, 6'd6, 6'd7:
            pd = PD_COND;
         // likely forms, assumed taken
         6'd20, 6'd21, 6'd22, 6'd23:
            pd = PD_ALWAYS;
         // jr, jalr and everything else
         default:
            pd = PD_NONE;
      endcase
   end

endmodule

// File: l1i/l1i_arrays.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_arrays
(
   input logic clk,
   input logic reset,
   input logic lookup_en,
   input logic [`FETCH_ADDR_W-1:0] lookup_pc,
   input logic sweep_en,
   input logic [`LG_L1I_SETS-1:0] sweep_idx,
   input logic [`FETCH_ADDR_W-1:0] refill_addr,
   input logic mem_rsp_valid,
   input mem_pkg::mem_rsp_t mem_rsp,
   output logic hit,
   output logic [31:0] line_word,
   output fetch_pkg::pd_class_t line_pd
);
   import fetch_pkg::*;

   localparam int SETS = 1 << `LG_L1I_SETS;
   localparam int WORDS = 1 << (`LG_CL_BYTES - 2);
   localparam int IDX_LO = `LG_CL_BYTES;
   localparam int IDX_HI = `LG_CL_BYTES + `LG_L1I_SETS;
   localparam int TAG_W = `FETCH_ADDR_W - IDX_HI;

   logic [SETS-1:0] valid_arr;
   logic [TAG_W-1:0] tag_arr [SETS];
   logic [32*WORDS-1:0] data_arr [SETS];
   pd_class_t [WORDS-1:0] pd_arr [SETS];
   pd_class_t [WORDS-1:0] refill_pd;

   logic [`LG_L1I_SETS-1:0] lookup_set;
   logic [`LG_L1I_SETS-1:0] refill_set;

   logic r_valid;
   logic [TAG_W-1:0] r_tag;
   logic [TAG_W-1:0] r_lookup_tag;
   logic [32*WORDS-1:0] r_line;
   pd_class_t [WORDS-1:0] r_pd;
   logic [`LG_CL_BYTES-3:0] r_word;

   assign lookup_set = lookup_pc[IDX_HI-1:IDX_LO];
   assign refill_set = refill_addr[IDX_HI-1:IDX_LO];

   // classify each word on its way into the array
   for (genvar i = 0; i < WORDS; i++)
   begin : g_pd
      predecode u_pd
      (
         .word(mem_rsp.line[32*i +: 32]),
         .pd(refill_pd[i])
      );
   end

   // sweep wins over refill, they never overlap in practice
   always_ff @(posedge clk)
   begin
      if (sweep_en)
         valid_arr[sweep_idx] <= 1'b0;
      else if (mem_rsp_valid)
         valid_arr[refill_set] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (mem_rsp_valid)
      begin
         tag_arr[refill_set] <= refill_addr[`FETCH_ADDR_W-1:IDX_HI];
         data_arr[refill_set] <= mem_rsp.line;
         pd_arr[refill_set] <= refill_pd;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         r_valid <= 1'b0;
      else if (lookup_en)
         r_valid <= valid_arr[lookup_set];
   end

   always_ff @(posedge clk)
   begin
      if (lookup_en)
      begin
         r_tag <= tag_arr[lookup_set];
         r_lookup_tag <= lookup_pc[`FETCH_ADDR_W-1:IDX_HI];
         r_line <= data_arr[lookup_set];
         r_pd <= pd_arr[lookup_set];
         r_word <= lookup_pc[IDX_LO-1:2];
      end
   end

   assign hit = r_valid && (r_tag == r_lookup_tag);
   assign line_word = r_line[32*r_word +: 32];
   assign line_pd = r_pd[r_word];

endmodule

// File: l1i/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_ctrl
(
   input logic clk,
   input logic reset,
   input logic restart_valid,
   input logic [`FETCH_ADDR_W-1:0] restart_pc,
   input logic flush_req,
   input logic init_done,
   input logic mem_rsp_valid,
   input logic hit,
   input logic [31:0] line_word,
   input fetch_pkg::pd_class_t line_pd,
   input logic counter_taken,
   input logic queue_full,
   output logic restart_ack,
   output logic flush_complete,
   output logic mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   output logic lookup_en,
   output logic [`FETCH_ADDR_W-1:0] lookup_pc,
   output logic sweep_en,
   output logic [`LG_L1I_SETS-1:0] sweep_idx,
   output logic [`FETCH_ADDR_W-1:0] refill_addr,
   output logic push,
   output fetch_pkg::fetch_insn_t push_insn,
   output logic queue_clear
);
   import fetch_pkg::*;
   import mem_pkg::*;

   localparam int AW = `FETCH_ADDR_W;

   fetch_state_t r_state, n_state;
   logic [AW-1:0] r_pc, n_pc;
   logic [AW-1:0] r_cache_pc;
   logic [AW-1:0] r_miss_pc, n_miss_pc;
   logic [AW-1:0] r_mem_addr, n_mem_addr;
   logic [`LG_L1I_SETS-1:0] r_sweep_idx;
   logic r_req;
   logic r_restart_req, n_restart_req;
   logic r_flush_req, n_flush_req;
   logic r_restart_ack, n_restart_ack;
   logic r_flush_complete, n_flush_complete;
   logic r_mem_req_valid, n_mem_req_valid;
   logic can_serve;
   logic take_br;
   logic [AW-1:0] simm;
   logic [AW-1:0] next_pc;

   // target of the word that hit last cycle
   always_comb
   begin
      simm = {{(AW-16){line_word[15]}}, line_word[15:0]};
      take_br = (line_pd == PD_JUMP) || (line_pd == PD_ALWAYS) ||
                (line_pd == PD_COND && counter_taken);
      if (line_pd == PD_JUMP)
         next_pc = {r_cache_pc[AW-1:28], line_word[25:0], 2'b00};
      else if (take_br)
         next_pc = r_cache_pc + 4 + {simm[AW-3:0], 2'b00};
      else
         next_pc = r_cache_pc + 4;
   end

   always_comb
   begin
      push_insn.data = line_word;
      push_insn.pc = r_cache_pc;
      push_insn.pred = take_br;
      push_insn.pred_cond = (line_pd == PD_COND);
   end

   always_comb
   begin
      n_state = r_state;
      // r_pc also holds a restart target that is waiting to be served
      n_pc = restart_valid ? restart_pc : r_pc;
      n_miss_pc = r_miss_pc;
      n_mem_addr = r_mem_addr;
      n_restart_req = r_restart_req | restart_valid;
      n_flush_req = r_flush_req | flush_req;
      n_restart_ack = 1'b0;
      n_flush_complete = 1'b0;
      n_mem_req_valid = 1'b0;
      lookup_en = 1'b0;
      lookup_pc = r_pc;
      sweep_en = 1'b0;
      push = 1'b0;
      queue_clear = 1'b0;
      can_serve = (r_state == IDLE) || (r_state == ACTIVE) ||
                  (r_state == RELOAD_TURNAROUND) || (r_state == WAIT_FOR_NOT_FULL);

      if (can_serve && n_flush_req)
      begin
         // sweep counter is back at set 0 after every full pass
         n_flush_req = 1'b0;
         queue_clear = 1'b1;
         n_state = FLUSH_CACHE;
      end
      else if (can_serve && n_restart_req)
      begin
         // any lookup in flight is simply not reissued
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         queue_clear = 1'b1;
         n_state = ACTIVE;
      end
      else
      begin
         case (r_state)
            INIT_PHT:
            begin
               if (init_done)
                  n_state = FLUSH_CACHE;
            end
            FLUSH_CACHE:
            begin
               sweep_en = 1'b1;
               if (r_sweep_idx == '1)
               begin
                  n_flush_complete = 1'b1;
                  n_state = IDLE;
               end
            end
            ACTIVE:
            begin
               if (!r_req)
                  lookup_en = 1'b1;
               else if (!hit)
               begin
                  n_miss_pc = r_cache_pc;
                  n_mem_addr = {r_cache_pc[AW-1:`LG_CL_BYTES], {`LG_CL_BYTES{1'b0}}};
                  n_mem_req_valid = 1'b1;
                  n_state = INJECT_RELOAD;
               end
               else if (queue_full)
               begin
                  n_miss_pc = r_cache_pc;
                  n_state = WAIT_FOR_NOT_FULL;
               end
               else
               begin
                  // redirect right away, no bubble on a taken prediction
                  push = 1'b1;
                  lookup_en = 1'b1;
                  lookup_pc = next_pc;
               end
            end
            INJECT_RELOAD:
            begin
               if (mem_rsp_valid)
                  n_state = RELOAD_TURNAROUND;
            end
            RELOAD_TURNAROUND:
            begin
               lookup_en = 1'b1;
               lookup_pc = r_miss_pc;
               n_state = ACTIVE;
            end
            WAIT_FOR_NOT_FULL:
            begin
               if (!queue_full)
               begin
                  lookup_en = 1'b1;
                  lookup_pc = r_miss_pc;
                  n_state = ACTIVE;
               end
            end
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= INIT_PHT;
         r_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_sweep_idx <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_req <= lookup_en;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_restart_ack <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_mem_req_valid <= n_mem_req_valid;
         if (sweep_en)
            r_sweep_idx <= r_sweep_idx + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_miss_pc <= n_miss_pc;
      r_mem_addr <= n_mem_addr;
      if (lookup_en)
         r_cache_pc <= lookup_pc;
   end

   assign restart_ack = r_restart_ack;
   assign flush_complete = r_flush_complete;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req.addr = r_mem_addr;
   assign mem_req.opcode = MEM_LW;
   assign refill_addr = r_mem_addr;
   assign sweep_idx = r_sweep_idx;

endmodule

// File: logic/branch_pht.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branch_pht
(
   input logic clk,
   input logic reset,
   input logic [`FETCH_ADDR_W-1:0] lookup_pc,
   input logic retire_br_valid,
   input fetch_pkg::retire_br_t retire_br,
   output logic counter_taken,
   output logic init_done
);
   localparam int ENTRIES = 1 << `LG_PHT_SZ;

   logic [1:0] pht [ENTRIES];
   logic [1:0] r_lookup_out;
   logic [1:0] r_upd_out;
   logic [1:0] upd_val;
   logic [1:0] wr_val;
   logic [`LG_PHT_SZ-1:0] r_init_idx;
   logic [`LG_PHT_SZ-1:0] r_upd_idx;
   logic [`LG_PHT_SZ-1:0] retire_idx;
   logic [`LG_PHT_SZ-1:0] wr_idx;
   logic r_upd_valid;
   logic r_upd_taken;
   logic wr_en;

   assign retire_idx = retire_br.pc[`LG_PHT_SZ+1:2];

   // saturating step toward the retired outcome
   always_comb
   begin
      upd_val = r_upd_out;
      if (r_upd_taken && r_upd_out != 2'd3)
         upd_val = r_upd_out + 2'd1;
      else if (!r_upd_taken && r_upd_out != 2'd0)
         upd_val = r_upd_out - 2'd1;
   end

   // reset sweep owns the write port, weakly not taken everywhere
   assign wr_en = !init_done || r_upd_valid;
   assign wr_idx = init_done ? r_upd_idx : r_init_idx;
   assign wr_val = init_done ? upd_val : 2'd1;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         pht[wr_idx] <= wr_val;
   end

   always_ff @(posedge clk)
   begin
      r_lookup_out <= pht[lookup_pc[`LG_PHT_SZ+1:2]];
      r_upd_idx <= retire_idx;
      r_upd_taken <= retire_br.taken;
      // forward so back-to-back reports to one entry both count
      if (wr_en && wr_idx == retire_idx)
         r_upd_out <= wr_val;
      else
         r_upd_out <= pht[retire_idx];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_init_idx <= '0;
         init_done <= 1'b0;
         r_upd_valid <= 1'b0;
      end
      else
      begin
         r_upd_valid <= retire_br_valid && init_done;
         if (!init_done)
         begin
            r_init_idx <= r_init_idx + 1'b1;
            init_done <= (r_init_idx == ENTRIES-1);
         end
      end
   end

   assign counter_taken = r_lookup_out[1];

endmodule

// File: logic/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue
(
   input logic clk,
   input logic reset,
   input logic clear,
   input logic push,
   input fetch_pkg::fetch_insn_t push_insn,
   input logic pop,
   output fetch_pkg::fetch_insn_t head,
   output logic valid,
   output logic full
);
   import fetch_pkg::*;

   localparam int ENTRIES = 1 << `LG_FQ_ENTRIES;

   fetch_insn_t mem [ENTRIES];
   logic [`LG_FQ_ENTRIES:0] r_head;
   logic [`LG_FQ_ENTRIES:0] r_tail;
   logic do_push;
   logic do_pop;

   assign valid = (r_head != r_tail);
   // same slot on opposite laps
   assign full = (r_head[`LG_FQ_ENTRIES] != r_tail[`LG_FQ_ENTRIES]) &&
                 (r_head[`LG_FQ_ENTRIES-1:0] == r_tail[`LG_FQ_ENTRIES-1:0]);
   assign head = mem[r_head[`LG_FQ_ENTRIES-1:0]];

   assign do_push = push && !full;
   assign do_pop = pop && valid;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[r_tail[`LG_FQ_ENTRIES-1:0]] <= push_insn;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         if (do_push)
            r_tail <= r_tail + 1'b1;
         if (do_pop)
            r_head <= r_head + 1'b1;
      end
   end

endmodule

// File: l1i/l1i_top.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_top
(
   input logic clk,
   input logic reset,
   input logic restart_valid,
   input logic [`FETCH_ADDR_W-1:0] restart_pc,
   output logic restart_ack,
   input logic flush_req,
   output logic flush_complete,
   input logic retire_br_valid,
   input fetch_pkg::retire_br_t retire_br,
   output fetch_pkg::fetch_insn_t insn,
   output logic insn_valid,
   input logic insn_ack,
   output logic mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   input logic mem_rsp_valid,
   input mem_pkg::mem_rsp_t mem_rsp
);
   import fetch_pkg::*;

   logic lookup_en;
   logic [`FETCH_ADDR_W-1:0] lookup_pc;
   logic sweep_en;
   logic [`LG_L1I_SETS-1:0] sweep_idx;
   logic [`FETCH_ADDR_W-1:0] refill_addr;
   logic hit;
   logic [31:0] line_word;
   pd_class_t line_pd;
   logic counter_taken;
   logic init_done;
   logic push;
   fetch_insn_t push_insn;
   logic queue_clear;
   logic queue_full;

   l1i_arrays u_arrays
   (
      .clk(clk),
      .reset(reset),
      .lookup_en(lookup_en),
      .lookup_pc(lookup_pc),
      .sweep_en(sweep_en),
      .sweep_idx(sweep_idx),
      .refill_addr(refill_addr),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp(mem_rsp),
      .hit(hit),
      .line_word(line_word),
      .line_pd(line_pd)
   );

   fetch_ctrl u_ctrl
   (
      .clk(clk),
      .reset(reset),
      .restart_valid(restart_valid),
      .restart_pc(restart_pc),
      .flush_req(flush_req),
      .init_done(init_done),
      .mem_rsp_valid(mem_rsp_valid),
      .hit(hit),
      .line_word(line_word),
      .line_pd(line_pd),
      .counter_taken(counter_taken),
      .queue_full(queue_full),
      .restart_ack(restart_ack),
      .flush_complete(flush_complete),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .lookup_en(lookup_en),
      .lookup_pc(lookup_pc),
      .sweep_en(sweep_en),
      .sweep_idx(sweep_idx),
      .refill_addr(refill_addr),
      .push(push),
      .push_insn(push_insn),
      .queue_clear(queue_clear)
   );

   // pht is indexed by the same pc the cache looks up
   branch_pht u_pht
   (
      .clk(clk),
      .reset(reset),
      .lookup_pc(lookup_pc),
      .retire_br_valid(retire_br_valid),
      .retire_br(retire_br),
      .counter_taken(counter_taken),
      .init_done(init_done)
   );

   fetch_queue u_queue
   (
      .clk(clk),
      .reset(reset),
      .clear(queue_clear),
      .push(push),
      .push_insn(push_insn),
      .pop(insn_ack),
      .head(insn),
      .valid(insn_valid),
      .full(queue_full)
   );

endmodule

// File: tests/l1i_assertions.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_assertions
(
   input logic clk,
   input logic reset,
   input logic restart_ack,
   input logic mem_req_valid,
   input logic insn_valid,
   input logic [`FETCH_ADDR_W-1:0] mem_req_addr
);
   int failures = 0;

   // single-cycle strobes
   ack_single: assert property (@(posedge clk) disable iff (reset) restart_ack |=> !restart_ack)
   else
   begin
      $error("restart_ack high for two cycles");
      failures++;
   end

   req_single: assert property (@(posedge clk) disable iff (reset)
                                mem_req_valid |=> !mem_req_valid)
   else
   begin
      $error("mem_req_valid high for two cycles");
      failures++;
   end

   empty_after_reset: assert property (@(posedge clk) reset |=> !insn_valid)
   else
   begin
      $error("insn_valid high right after reset");
      failures++;
   end

   // refills always fetch whole lines
   req_aligned: assert property (@(posedge clk) disable iff (reset)
                                 mem_req_valid |-> mem_req_addr[`LG_CL_BYTES-1:0] == '0)
   else
   begin
      $error("mem_req address not line aligned");
      failures++;
   end

endmodule

// File: tests/l1i_tb.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_tb;
   import fetch_pkg::*;
   import mem_pkg::*;

   localparam logic [31:0] BASE = 32'h0000_1000;
   localparam int IMG_WORDS = 256;
   localparam int N_SEQ = 64;
   localparam int N_CF = 48;
   localparam int N_BR = 4;
   localparam int N_BP = 40;
   localparam int INIT_BUDGET = 300;
   localparam int CYC_PER_INSN = 30;
   localparam int LIMIT = INIT_BUDGET + CYC_PER_INSN * (N_SEQ + N_CF + 2 * N_BR + 2 * N_BP) + 2000;

   logic clk;
   logic reset;
   logic restart_valid;
   logic [31:0] restart_pc;
   logic restart_ack;
   logic flush_req;
   logic flush_complete;
   logic retire_br_valid;
   retire_br_t retire_br;
   fetch_insn_t insn;
   logic insn_valid;
   logic insn_ack;
   logic mem_req_valid;
   mem_req_t mem_req;
   logic mem_rsp_valid;
   mem_rsp_t mem_rsp;

   logic [31:0] rng;
   logic [31:0] image [IMG_WORDS];
   int pht_m [1 << `LG_PHT_SZ];
   bit requested [logic [31:0]];
   logic [31:0] m_pc;
   logic [31:0] mem_addr;
   int cycles = 0;
   int fc_count = 0;
   int ack_count = 0;
   int req_count = 0;
   int mem_pending = 0;
   int mem_wait = 0;
   int n_checks = 0;
   int n_errors = 0;
   int test_base = 0;
   int n_direct = 0;

   l1i_top i_dut
   (
      .clk(clk),
      .reset(reset),
      .restart_valid(restart_valid),
      .restart_pc(restart_pc),
      .restart_ack(restart_ack),
      .flush_req(flush_req),
      .flush_complete(flush_complete),
      .retire_br_valid(retire_br_valid),
      .retire_br(retire_br),
      .insn(insn),
      .insn_valid(insn_valid),
      .insn_ack(insn_ack),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp(mem_rsp)
   );

   bind l1i_top l1i_assertions i_checks
   (
      .clk(clk),
      .reset(reset),
      .restart_ack(restart_ack),
      .mem_req_valid(mem_req_valid),
      .insn_valid(insn_valid),
      .mem_req_addr(mem_req.addr)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      while (cycles < LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Test failures found");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // r-type filler outside the code image folds in every address bit
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      if (addr >= BASE && addr < BASE + 4 * IMG_WORDS)
         return image[addr[9:2]];
      return {6'd0, addr[25:0] ^ {addr[31:26], 20'd0}};
   endfunction

   // branch classes as the core's isa defines them
   function automatic pd_class_t pd_of(input logic [31:0] word);
      logic [4:0] rs;
      logic [4:0] rt;
      rs = word[25:21];
      rt = word[20:16];
      case (word[31:26])
         6'd1:
            case (rt)
               5'd0, 5'd1, 5'd16, 5'd17: return PD_COND;
               5'd2, 5'd3, 5'd18, 5'd19: return PD_ALWAYS;
               default: return PD_NONE;
            endcase
         6'd2, 6'd3:
            return PD_JUMP;
         6'd4:
            return (rs == 5'd0 && rt == 5'd0) ? PD_ALWAYS : PD_COND;
         6'd5, 6'd6, 6'd7:
            return PD_COND;
         6'd20, 6'd21, 6'd22, 6'd23:
            return PD_ALWAYS;
         default:
            return PD_NONE;
      endcase
   endfunction

   function automatic int find_word(input pd_class_t a, input pd_class_t b);
      for (int i = 0; i < IMG_WORDS; i++)
      begin
         if (pd_of(image[i]) == a || pd_of(image[i]) == b)
            return i;
      end
      return 0;
   endfunction

   task automatic build_image();
      logic [31:0] r;
      logic [15:0] off;
      for (int i = 0; i < IMG_WORDS; i++)
      begin
         r = next_rand();
         // short hops of -8 to +7 words
         off = {{12{r[7]}}, r[7:4]};
         case (r[3:0])
            4'd0: image[i] = {6'd2, 26'h400 | {18'd0, r[15:8]}};
            4'd1: image[i] = {6'd4, 5'd0, 5'd0, off};
            4'd2: image[i] = {6'd5, r[20:16], r[25:21], off};
            4'd3: image[i] = {6'd1, r[20:16], 5'd1, off};
            4'd4: image[i] = {6'd20, r[20:16], r[25:21], off};
            default: image[i] = {6'd0, r[31:6]};
         endcase
      end
   endtask

   // one negedge plus the memory responder
   task automatic step();
      @(negedge clk);
      restart_valid = 1'b0;
      flush_req = 1'b0;
      retire_br_valid = 1'b0;
      mem_rsp_valid = 1'b0;
      insn_ack = 1'b0;
      if (flush_complete)
      begin
         fc_count++;
         requested.delete();
      end
      if (restart_ack)
         ack_count++;
      if (mem_pending != 0)
      begin
         if (mem_wait == 0)
         begin
            for (int i = 0; i < 4; i++)
               mem_rsp.line[32 * i +: 32] = mem_word(mem_addr + 4 * i);
            mem_rsp_valid = 1'b1;
            mem_pending = 0;
         end
         else
            mem_wait--;
      end
      if (mem_req_valid)
      begin
         req_count++;
         // instruction refills are always line reads
         check_value("mem_req.opcode", mem_req.opcode, MEM_LW);
         requested[mem_req.addr] = 1'b1;
         mem_addr = mem_req.addr;
         mem_pending = 1;
         mem_wait = next_rand() % 6;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      n_checks++;
      assert (cond)
      else
      begin
         $display("failure at %0t: %s", $time, what);
         n_errors++;
      end
   endtask

   // compare the head entry with the model and step the model pc
   task automatic expect_insn();
      logic [31:0] word;
      logic [31:0] simm;
      logic [31:0] target;
      logic taken;
      pd_class_t cls;
      word = mem_word(m_pc);
      cls = pd_of(word);
      simm = {{16{word[15]}}, word[15:0]};
      taken = (cls == PD_JUMP) || (cls == PD_ALWAYS) ||
              (cls == PD_COND && pht_m[m_pc[`LG_PHT_SZ+1:2]] >= 2);
      if (cls == PD_JUMP)
         target = {m_pc[31:28], word[25:0], 2'b00};
      else
         target = m_pc + 4 + (simm << 2);
      check_value("insn.pc", insn.pc, m_pc);
      check_value("insn.data", insn.data, word);
      check_value("insn.pred", insn.pred, taken);
      check_value("insn.pred_cond", insn.pred_cond, cls == PD_COND);
      check_true(requested.exists({insn.pc[31:`LG_CL_BYTES], {`LG_CL_BYTES{1'b0}}}),
                 "instruction came from a line not requested since the last flush");
      if ((cls == PD_JUMP || cls == PD_ALWAYS) && insn.pred === 1'b1)
         n_direct++;
      m_pc = taken ? target : m_pc + 4;
   endtask

   task automatic restart_to(input logic [31:0] pc, output int waited);
      int acks;
      step();
      acks = ack_count;
      restart_valid = 1'b1;
      restart_pc = pc;
      waited = 0;
      while (ack_count == acks)
      begin
         step();
         waited++;
      end
      m_pc = pc;
   endtask

   task automatic flush_cache();
      int fcs;
      step();
      fcs = fc_count;
      flush_req = 1'b1;
      while (fc_count == fcs)
         step();
   endtask

   task automatic report_branch(input logic [31:0] pc, input logic taken);
      int idx;
      step();
      retire_br_valid = 1'b1;
      retire_br.pc = pc;
      retire_br.taken = taken;
      idx = pc[`LG_PHT_SZ+1:2];
      if (taken && pht_m[idx] < 3)
         pht_m[idx]++;
      else if (!taken && pht_m[idx] > 0)
         pht_m[idx]--;
   endtask

   task automatic pop_insns(input int n, input logic random_ack);
      int popped;
      popped = 0;
      while (popped < n)
      begin
         step();
         if (insn_valid && (!random_ack || next_rand() % 4 != 0))
         begin
            expect_insn();
            insn_ack = 1'b1;
            popped++;
         end
      end
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s finished with %0d errors", num, name, n_errors - test_base);
      test_base = n_errors;
   endtask

   initial
   begin
      int waited;
      int idx;
      int reqs_before;
      int total;
      logic [31:0] br_pc;
      logic [31:0] r;
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      flush_req = 1'b0;
      retire_br_valid = 1'b0;
      retire_br = '0;
      insn_ack = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp = '0;
      rng = 32'd88550;
      for (int i = 0; i < (1 << `LG_PHT_SZ); i++)
         pht_m[i] = 1;
      build_image();
      repeat (8)
         step();
      reset = 1'b0;

      while (fc_count == 0)
      begin
         check_value("insn_valid", insn_valid, 1'b0);
         step();
      end
      // quiet window before any restart
      repeat (20)
      begin
         step();
         check_value("insn_valid", insn_valid, 1'b0);
      end
      check_value("flush_complete pulses", fc_count, 1);
      check_value("mem_req_valid pulses", req_count, 0);
      end_test(1, "initialization");

      restart_to(BASE, waited);
      check_value("restart_ack latency", waited, 1);
      pop_insns(N_SEQ, 1'b1);
      end_test(2, "sequential fetch and refill");

      idx = find_word(PD_JUMP, PD_ALWAYS);
      n_direct = 0;
      restart_to(BASE + 4 * idx, waited);
      pop_insns(N_CF, 1'b1);
      check_true(n_direct > 0, "no jump or always-taken branch was fetched as taken");
      end_test(3, "direct control flow");

      idx = find_word(PD_COND, PD_COND);
      br_pc = BASE + 4 * idx;
      restart_to(br_pc, waited);
      pop_insns(1, 1'b0);
      check_value("insn.pred", insn.pred, 1'b0);
      pop_insns(N_BR - 1, 1'b1);
      flush_cache();
      // train while the fetch unit sits in idle
      repeat (6)
      begin
         r = next_rand();
         report_branch(BASE + {22'd0, r[9:2], 2'b00}, r[0]);
      end
      report_branch(br_pc, 1'b1);
      report_branch(br_pc, 1'b1);
      restart_to(br_pc, waited);
      pop_insns(1, 1'b0);
      check_value("insn.pred", insn.pred, 1'b1);
      check_value("insn.pred_cond", insn.pred_cond, 1'b1);
      pop_insns(N_BR - 1, 1'b1);
      end_test(4, "pht prediction");

      restart_to(BASE + 32'h40, waited);
      while (!i_dut.queue_full)
         step();
      repeat (4)
         step();
      pop_insns(N_BP, 1'b1);
      flush_cache();
      reqs_before = req_count;
      restart_to(BASE + 32'h40, waited);
      pop_insns(N_BP, 1'b1);
      check_true(req_count > reqs_before, "no refill request after the flush");
      end_test(5, "back-pressure and flush");

      total = n_errors + i_dut.i_checks.failures;
      $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
               n_checks, n_errors, i_dut.i_checks.failures);
      if (total == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+common
common/fetch_pkg.sv
common/mem_pkg.sv
l1i/predecode.sv
l1i/l1i_arrays.sv
l1i/fetch_ctrl.sv
logic/branch_pht.sv
logic/fetch_queue.sv
l1i/l1i_top.sv
tests/l1i_assertions.sv
tests/l1i_tb.sv
